/* source/riscboy_periph_macros.svh */
// Offsets are 12-bit byte offsets within a 4 KiB slot picked by paddr[15:12], and pad count stays in 1 to 32
`ifndef RISCBOY_PERIPH_MACROS_SVH
`define RISCBOY_PERIPH_MACROS_SVH

// ================================================
//  Bus and datapath widths
// ================================================

`define RB_W_PADDR    16
`define RB_W_DATA     32
`define RB_N_PADS     8
`define RB_W_PWM_CTR  8

// Slot numbers in the upper address nibble
`define RB_SLOT_GPIO  4'h0
`define RB_SLOT_PWM   4'h1

// ================================================
//  Register offsets and reset values
// ================================================

`define RB_GPIO_OUT   12'h000
`define RB_GPIO_OE    12'h004
`define RB_GPIO_IN    12'h008 // Read only
`define RB_GPIO_FSEL  12'h00c

`define RB_PWM_CTRL   12'h000 // Bit 0 enable, bit 1 invert
`define RB_PWM_CMP    12'h004

`define RB_GPIO_OUT_RST  '0
`define RB_GPIO_OE_RST   '0
`define RB_GPIO_FSEL_RST 1'b0
`define RB_PWM_CTRL_RST  2'b00
`define RB_PWM_CMP_RST   '0

`endif

/* source/riscboy_periph_pkg.sv */
// APB carries no PREADY here since every slave answers in its first access cycle
`include "riscboy_periph_macros.svh"

package riscboy_periph_pkg;

	// ================================================
	//  APB request, master to slave
	// ================================================

	typedef struct packed {
		logic [`RB_W_PADDR-1:0] paddr;
		logic                   pwrite;
		logic [`RB_W_DATA-1:0]  pwdata;
		logic                   psel;
		logic                   penable; // High in the access phase only
	} apb_req_t;

	// ================================================
	//  APB response, slave to master
	// ================================================

	// Valid combinationally during the access phase
	typedef struct packed {
		logic [`RB_W_DATA-1:0] prdata;
		logic                  pslverr;
	} apb_rsp_t;

endpackage

/* source/apb_splitter.sv */
// Purely combinational, decodes paddr[15:12] only and answers unmapped slots with an error
`timescale 1ns/1ps
`include "riscboy_periph_macros.svh"

module apb_splitter (
	input  riscboy_periph_pkg::apb_req_t req,
	output riscboy_periph_pkg::apb_rsp_t rsp,

	output riscboy_periph_pkg::apb_req_t gpio_req,
	input  riscboy_periph_pkg::apb_rsp_t gpio_rsp,

	output riscboy_periph_pkg::apb_req_t pwm_req,
	input  riscboy_periph_pkg::apb_rsp_t pwm_rsp
);

import riscboy_periph_pkg::*;

logic [3:0] slot;
logic       hit_gpio;
logic       hit_pwm;
apb_rsp_t   unmapped_rsp;

assign slot = req.paddr[`RB_W_PADDR-1 -: 4];

assign hit_gpio = slot == `RB_SLOT_GPIO;
assign hit_pwm  = slot == `RB_SLOT_PWM;

// ================================================
//  Request fan-out
// ================================================

// Everything but psel goes to both slots unchanged
always_comb begin
	gpio_req      = req;
	gpio_req.psel = req.psel & hit_gpio;
	pwm_req       = req;
	pwm_req.psel  = req.psel & hit_pwm;
end

// ================================================
//  Response mux
// ================================================

// Nobody home, so flag an error whenever the slot is addressed
always_comb begin
	unmapped_rsp.prdata  = '0;
	unmapped_rsp.pslverr = req.psel;
end

always_comb begin
	if (hit_gpio) begin
		rsp = gpio_rsp;
	end else if (hit_pwm) begin
		rsp = pwm_rsp;
	end else begin
		rsp = unmapped_rsp;
	end
end

endmodule

/* source/gpio.sv */
// Zero wait state APB slave, N_PADS up to 32, pad_in is asynchronous and goes through two flops
`timescale 1ns/1ps
`include "riscboy_periph_macros.svh"

module gpio #(
	parameter int N_PADS = `RB_N_PADS
) (
	input  logic                         clk_sys,
	input  logic                         reset,

	input  riscboy_periph_pkg::apb_req_t req,
	output riscboy_periph_pkg::apb_rsp_t rsp,

	input  logic                         pwm_out, // Alternate function for pad 0
	output logic [N_PADS-1:0]            pad_out,
	output logic [N_PADS-1:0]            pad_oe,
	input  logic [N_PADS-1:0]            pad_in
);

logic [N_PADS-1:0]     out_reg;
logic [N_PADS-1:0]     oe_reg;
logic                  fsel_reg;  // Hands pad 0 to the PWM
logic [N_PADS-1:0]     in_meta;   // First synchronizer stage
logic [N_PADS-1:0]     in_reg;

logic [11:0]           offset;
logic                  wen;
logic                  reg_hit;
logic                  reg_ro;
logic                  bad_access;
logic [`RB_W_DATA-1:0] rd_data;

assign offset = req.paddr[11:0];
assign wen    = req.psel & req.penable & req.pwrite;

// ================================================
//  Register writes
// ================================================

// Writes land on the edge that closes the access phase
always_ff @(posedge clk_sys) begin
	if (reset) begin
		out_reg  <= `RB_GPIO_OUT_RST;
		oe_reg   <= `RB_GPIO_OE_RST;
		fsel_reg <= `RB_GPIO_FSEL_RST;
	end else if (wen) begin
		case (offset)
			`RB_GPIO_OUT:  out_reg  <= req.pwdata[N_PADS-1:0];
			`RB_GPIO_OE:   oe_reg   <= req.pwdata[N_PADS-1:0];
			`RB_GPIO_FSEL: fsel_reg <= req.pwdata[0];
			default: ; // IN and holes are left alone
		endcase
	end
end

// Input synchronizer, IN settles two edges after a pad moves
always_ff @(posedge clk_sys) begin
	in_meta <= pad_in;
	in_reg  <= in_meta;
end

// ================================================
//  Pad drive
// ================================================

always_comb begin
	pad_out = out_reg;
	pad_oe  = oe_reg;
	if (fsel_reg) begin
		pad_out[0] = pwm_out;
		pad_oe[0]  = 1'b1;
	end
end

// ================================================
//  Readback and error
// ================================================

always_comb begin
	rd_data = '0;
	reg_hit = 1'b1;
	reg_ro  = 1'b0;
	case (offset)
		`RB_GPIO_OUT:  rd_data[N_PADS-1:0] = out_reg;
		`RB_GPIO_OE:   rd_data[N_PADS-1:0] = oe_reg;
		`RB_GPIO_IN: begin
			rd_data[N_PADS-1:0] = in_reg;
			reg_ro = 1'b1;
		end
		`RB_GPIO_FSEL: rd_data[0] = fsel_reg;
		default:       reg_hit = 1'b0;
	endcase
end

// Unknown offset, or a write to the read-only IN register
assign bad_access = !reg_hit || (req.pwrite && reg_ro);

assign rsp.prdata  = (req.pwrite || bad_access) ? '0 : rd_data;
assign rsp.pslverr = req.psel & bad_access;

endmodule

/* source/pwm_tiny.sv */
// Free-running 8-bit PWM, one output, zero wait state APB slave with registered pwm_out
`timescale 1ns/1ps
`include "riscboy_periph_macros.svh"

module pwm_tiny (
	input  logic                         clk_sys,
	input  logic                         reset,

	input  riscboy_periph_pkg::apb_req_t req,
	output riscboy_periph_pkg::apb_rsp_t rsp,

	output logic                         pwm_out
);

logic [1:0]               ctrl;   // Bit 0 enable, bit 1 invert
logic [`RB_W_PWM_CTR-1:0] cmp;
logic [`RB_W_PWM_CTR-1:0] ctr;

logic [11:0]              offset;
logic                     wen;
logic                     reg_hit;
logic [`RB_W_DATA-1:0]    rd_data;

assign offset = req.paddr[11:0];
assign wen    = req.psel & req.penable & req.pwrite;

// ================================================
//  Control registers
// ================================================

always_ff @(posedge clk_sys) begin
	if (reset) begin
		ctrl <= `RB_PWM_CTRL_RST;
		cmp  <= `RB_PWM_CMP_RST;
	end else if (wen) begin
		case (offset)
			`RB_PWM_CTRL: ctrl <= req.pwdata[1:0];
			`RB_PWM_CMP:  cmp  <= req.pwdata[`RB_W_PWM_CTR-1:0];
			default: ;
		endcase
	end
end

// ================================================
//  Counter and output
// ================================================

// Counter wraps mod 256, so output is high CMP cycles out of every 256
always_ff @(posedge clk_sys) begin
	if (reset) begin
		ctr     <= '0;
		pwm_out <= 1'b0;
	end else if (ctrl[0]) begin
		ctr     <= ctr + 1'b1;
		pwm_out <= (ctr < cmp) ^ ctrl[1];
	end else begin
		ctr     <= '0; // Parked, next enable starts a fresh period
		pwm_out <= 1'b0;
	end
end

// Readback
always_comb begin
	rd_data = '0;
	reg_hit = 1'b1;
	case (offset)
		`RB_PWM_CTRL: rd_data[1:0] = ctrl;
		`RB_PWM_CMP:  rd_data[`RB_W_PWM_CTR-1:0] = cmp;
		default:      reg_hit = 1'b0;
	endcase
end

assign rsp.prdata  = (req.pwrite || !reg_hit) ? '0 : rd_data;
assign rsp.pslverr = req.psel & !reg_hit;

endmodule

/* source/riscboy_periph.sv */
// APB peripheral top, slot 0 is GPIO and slot 1 is PWM, every transfer takes exactly two cycles
`timescale 1ns/1ps
`include "riscboy_periph_macros.svh"

module riscboy_periph #(
	parameter int N_PADS = `RB_N_PADS
) (
	input  logic                         clk_sys,
	input  logic                         reset,

	input  riscboy_periph_pkg::apb_req_t req,
	output riscboy_periph_pkg::apb_rsp_t rsp,

	output logic [N_PADS-1:0]            pad_out,
	output logic [N_PADS-1:0]            pad_oe,
	input  logic [N_PADS-1:0]            pad_in
);

import riscboy_periph_pkg::*;

// ================================================
//  Interconnect
// ================================================

apb_req_t gpio_req;
apb_rsp_t gpio_rsp;
apb_req_t pwm_req;
apb_rsp_t pwm_rsp;

logic     pwm_out; // PWM to pad 0 via the GPIO function select

apb_splitter inst_apb_splitter (
	.req      (req),
	.rsp      (rsp),
	.gpio_req (gpio_req),
	.gpio_rsp (gpio_rsp),
	.pwm_req  (pwm_req),
	.pwm_rsp  (pwm_rsp)
);

// ================================================
//  Slaves
// ================================================

gpio #(
	.N_PADS (N_PADS)
) inst_gpio (
	.clk_sys (clk_sys),
	.reset   (reset),
	.req     (gpio_req),
	.rsp     (gpio_rsp),
	.pwm_out (pwm_out),
	.pad_out (pad_out),
	.pad_oe  (pad_oe),
	.pad_in  (pad_in)
);

pwm_tiny inst_pwm_tiny (
	.clk_sys (clk_sys),
	.reset   (reset),
	.req     (pwm_req),
	.rsp     (pwm_rsp),
	.pwm_out (pwm_out)
);

endmodule

/* tests/tb_riscboy_periph.sv */
// Drives the APB port on falling edges, stops at the first mismatch, expects N_PADS up to 32
`timescale 1ns/1ps
`include "riscboy_periph_macros.svh"

module tb_riscboy_periph;

import riscboy_periph_pkg::*;

localparam int N_PADS       = `RB_N_PADS;
localparam int CLK_PERIOD   = 20;
localparam int RESET_CYCLES = 16;
localparam int PWM_PERIOD   = 256;
localparam int WAIT_LIMIT   = 64;

localparam logic WR  = 1'b1;
localparam logic RD  = 1'b0;
localparam logic OK  = 1'b0;
localparam logic ERR = 1'b1;

localparam logic [`RB_W_PADDR-1:0] A_OUT      = {`RB_SLOT_GPIO, `RB_GPIO_OUT};
localparam logic [`RB_W_PADDR-1:0] A_OE       = {`RB_SLOT_GPIO, `RB_GPIO_OE};
localparam logic [`RB_W_PADDR-1:0] A_IN       = {`RB_SLOT_GPIO, `RB_GPIO_IN};
localparam logic [`RB_W_PADDR-1:0] A_FSEL     = {`RB_SLOT_GPIO, `RB_GPIO_FSEL};
localparam logic [`RB_W_PADDR-1:0] A_CTRL     = {`RB_SLOT_PWM, `RB_PWM_CTRL};
localparam logic [`RB_W_PADDR-1:0] A_CMP      = {`RB_SLOT_PWM, `RB_PWM_CMP};
localparam logic [`RB_W_PADDR-1:0] A_GPIO_BAD = {`RB_SLOT_GPIO, 12'h010};
localparam logic [`RB_W_PADDR-1:0] A_PWM_BAD  = {`RB_SLOT_PWM, 12'h008};
localparam logic [`RB_W_PADDR-1:0] A_UNMAPPED = 16'h2000;

// One transfer with its expected response
typedef struct packed {
	logic                   wr;
	logic [`RB_W_PADDR-1:0] addr;
	logic [`RB_W_DATA-1:0]  wdata;
	logic [`RB_W_DATA-1:0]  rdata;
	logic                   err;
} xfer_t;

logic              clk_sys;
logic              reset;
apb_req_t          req;
apb_rsp_t          rsp;
logic [N_PADS-1:0] pad_out;
logic [N_PADS-1:0] pad_oe;
logic [N_PADS-1:0] pad_in;

integer            seed;
xfer_t             table_q[$];

riscboy_periph #(
	.N_PADS (N_PADS)
) dut_i (
	.clk_sys (clk_sys),
	.reset   (reset),
	.req     (req),
	.rsp     (rsp),
	.pad_out (pad_out),
	.pad_oe  (pad_oe),
	.pad_in  (pad_in)
);

always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

// ================================================
//  Helpers
// ================================================

// Registers only keep the low N_PADS bits
function automatic logic [`RB_W_DATA-1:0] pad_mask(input logic [`RB_W_DATA-1:0] value);
	return value & ({`RB_W_DATA{1'b1}} >> (`RB_W_DATA - N_PADS));
endfunction

function automatic xfer_t make_entry(input logic wr, input logic [`RB_W_PADDR-1:0] addr,
		input logic [`RB_W_DATA-1:0] wdata, input logic [`RB_W_DATA-1:0] rdata,
		input logic err);
	xfer_t e;
	e.wr    = wr;
	e.addr  = addr;
	e.wdata = wdata;
	e.rdata = rdata;
	e.err   = err;
	return e;
endfunction

task automatic stop_on_failure(input string reason);
	$display("%s", reason);
	$display("Done: errors found");
	$fatal(1, "Simulation stopped");
endtask

task automatic check_value(input string what, input logic [`RB_W_DATA-1:0] actual,
		input logic [`RB_W_DATA-1:0] expected);
	if (actual !== expected) begin
		stop_on_failure($sformatf("ERROR at %0t: %s is 0x%0h, expected 0x%0h",
			$time, what, actual, expected));
	end
endtask

task automatic wait_cycles(input int n);
	for (int i = 0; i < n; i++) begin
		@(negedge clk_sys);
	end
endtask

// Setup then access, response sampled in the middle of the access phase
task automatic apb_transfer(input xfer_t e, output apb_rsp_t got);
	@(negedge clk_sys);
	req.paddr   = e.addr;
	req.pwrite  = e.wr;
	req.pwdata  = e.wdata;
	req.psel    = 1'b1;
	req.penable = 1'b0;
	@(negedge clk_sys);
	req.penable = 1'b1; // Completes at the next rising edge
	#(CLK_PERIOD / 4);
	got = rsp;
	@(negedge clk_sys);
	req.psel    = 1'b0;
	req.penable = 1'b0;
endtask

task automatic run_entry(input xfer_t e);
	apb_rsp_t got;
	apb_transfer(e, got);
	check_value($sformatf("pslverr at 0x%04h", e.addr), 32'(got.pslverr), 32'(e.err));
	if (!e.wr || e.err) begin
		check_value($sformatf("prdata at 0x%04h", e.addr), got.prdata, e.rdata);
	end
endtask

task automatic count_pad0_high(output int count);
	count = 0;
	for (int i = 0; i < PWM_PERIOD; i++) begin
		@(negedge clk_sys);
		if (pad_out[0] === 1'b1) begin
			count++;
		end
	end
endtask

task automatic wait_pad0_low();
	int n;
	n = 0;
	while (pad_out[0] !== 1'b0 && n < WAIT_LIMIT) begin
		@(negedge clk_sys);
		n++;
	end
	if (pad_out[0] !== 1'b0) begin
		stop_on_failure("Timeout: pad 0 did not go low after the PWM was disabled");
	end
endtask

// ================================================
//  Stimulus
// ================================================

initial begin
	int                rnd;
	logic [N_PADS-1:0] pad_val;
	logic [7:0]        cmp_val;
	int                high_count;

	seed        = 88169;
	clk_sys     = 1'b0;
	reset       = 1'b1;
	req         = '0;
	pad_in      = '0;

	for (int i = 0; i < RESET_CYCLES; i++) begin
		@(posedge clk_sys);
	end
	@(negedge clk_sys);
	reset = 1'b0;

	check_value("pad_oe after reset", 32'(pad_oe), 32'h0);
	check_value("pad_out after reset", 32'(pad_out), 32'h0);

	// Reset values
	table_q.push_back(make_entry(RD, A_OUT, 32'h0, 32'h0, OK));
	table_q.push_back(make_entry(RD, A_OE, 32'h0, 32'h0, OK));
	table_q.push_back(make_entry(RD, A_FSEL, 32'h0, 32'h0, OK));
	table_q.push_back(make_entry(RD, A_CTRL, 32'h0, 32'h0, OK));
	table_q.push_back(make_entry(RD, A_CMP, 32'h0, 32'h0, OK));
	// Output path
	table_q.push_back(make_entry(WR, A_OUT, 32'h5a3c_00a5, 32'h0, OK));
	table_q.push_back(make_entry(RD, A_OUT, 32'h0, pad_mask(32'h5a3c_00a5), OK));
	table_q.push_back(make_entry(WR, A_OE, 32'hffff_ff3c, 32'h0, OK));
	table_q.push_back(make_entry(RD, A_OE, 32'h0, pad_mask(32'hffff_ff3c), OK));
	// Error responses, none of which may touch a register
	table_q.push_back(make_entry(WR, A_UNMAPPED, 32'hffff_ffff, 32'h0, ERR));
	table_q.push_back(make_entry(RD, A_UNMAPPED, 32'h0, 32'h0, ERR));
	table_q.push_back(make_entry(WR, A_IN, 32'hffff_ffff, 32'h0, ERR));
	table_q.push_back(make_entry(WR, A_GPIO_BAD, 32'hffff_ffff, 32'h0, ERR));
	table_q.push_back(make_entry(RD, A_GPIO_BAD, 32'h0, 32'h0, ERR));
	table_q.push_back(make_entry(RD, A_PWM_BAD, 32'h0, 32'h0, ERR));
	table_q.push_back(make_entry(RD, A_OUT, 32'h0, pad_mask(32'h5a3c_00a5), OK));
	table_q.push_back(make_entry(RD, A_OE, 32'h0, pad_mask(32'hffff_ff3c), OK));
	table_q.push_back(make_entry(RD, A_FSEL, 32'h0, 32'h0, OK));
	table_q.push_back(make_entry(RD, A_CTRL, 32'h0, 32'h0, OK));
	table_q.push_back(make_entry(RD, A_CMP, 32'h0, 32'h0, OK));

	foreach (table_q[i]) begin
		run_entry(table_q[i]);
		if (table_q[i].wr && !table_q[i].err) begin
			wait_cycles(1); // A cycle after the access edge
			if (table_q[i].addr == A_OUT) begin
				check_value("pad_out", 32'(pad_out), pad_mask(table_q[i].wdata));
			end
			if (table_q[i].addr == A_OE) begin
				check_value("pad_oe", 32'(pad_oe), pad_mask(table_q[i].wdata));
			end
		end
	end

	// Input path through the two-flop synchronizer
	rnd     = $random(seed);
	pad_val = rnd[N_PADS-1:0];
	@(negedge clk_sys);
	pad_in = pad_val;
	wait_cycles(3);
	run_entry(make_entry(RD, A_IN, 32'h0, 32'(pad_val), OK));

	// ================================================
	//  PWM on pad 0
	// ================================================

	rnd     = $random(seed);
	cmp_val = rnd[7:0];
	run_entry(make_entry(WR, A_CMP, 32'(cmp_val), 32'h0, OK));
	run_entry(make_entry(WR, A_FSEL, 32'h1, 32'h0, OK));
	run_entry(make_entry(WR, A_CTRL, 32'h1, 32'h0, OK));
	check_value("pad_oe[0] with FSEL set", 32'(pad_oe[0]), 32'h1);

	count_pad0_high(high_count);
	check_value("PWM high count", high_count, 32'(cmp_val));

	run_entry(make_entry(WR, A_CTRL, 32'h3, 32'h0, OK)); // Enable plus invert
	count_pad0_high(high_count);
	check_value("inverted PWM high count", high_count, 32'(PWM_PERIOD) - 32'(cmp_val));

	run_entry(make_entry(WR, A_CTRL, 32'h0, 32'h0, OK));
	wait_pad0_low();
	count_pad0_high(high_count);
	check_value("disabled PWM high count", high_count, 32'h0);

	run_entry(make_entry(RD, A_CMP, 32'h0, 32'(cmp_val), OK));
	run_entry(make_entry(RD, A_CTRL, 32'h0, 32'h0, OK));
	run_entry(make_entry(RD, A_FSEL, 32'h0, 32'h1, OK));

	$display("Done: no errors");
	$finish;
end

endmodule

/* riscboy_periph.f */
+incdir+source
source/riscboy_periph_pkg.sv
source/apb_splitter.sv
source/gpio.sv
source/pwm_tiny.sv
source/riscboy_periph.sv
tests/tb_riscboy_periph.sv

/* Makefile */
# Verilator build and run for riscboy_periph

TOP = tb_riscboy_periph

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 -f riscboy_periph.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing -f riscboy_periph.f \
		--top-module riscboy_periph

clean:
	rm -rf obj_dir
